// ==== mips_pkg.sv ====
package mips_pkg;

	// Data and address width
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;   // Register index width

	localparam int OPCODE_W = 6;
	localparam int FUNCT_W  = 6;
	localparam int SHAMT_W  = 5;
	localparam int IMM_W    = 16;

	// Field positions in the instruction word
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;
	localparam int SHAMT_LSB  = 6;

	typedef enum logic [OPCODE_W-1:0] {
		OP_RTYPE = 6'b000000,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111
	} opcode_e;

	typedef enum logic [FUNCT_W-1:0] {
		F_SLL  = 6'b000000,
		F_SRL  = 6'b000010,
		F_SRA  = 6'b000011,
		F_ADD  = 6'b100000,
		F_ADDU = 6'b100001,
		F_SUB  = 6'b100010,
		F_SUBU = 6'b100011,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_XOR  = 6'b100110,
		F_NOR  = 6'b100111,
		F_SLT  = 6'b101010,
		F_SLTU = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

endpackage

// ==== instr_mem.sv ====
`timescale 1ns/100ps

module instr_mem #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                       clock,
	input  logic                       load_en,
	input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
	input  logic [mips_pkg::XLEN-1:0]  load_data,
	input  logic                       fetch_en,
	input  logic [$clog2(MEM_WORDS)-1:0] fetch_addr,
	output logic [mips_pkg::XLEN-1:0]  insn
);

	logic [mips_pkg::XLEN-1:0] mem [MEM_WORDS];

	// Program load, only used while the core is idle
	always_ff @(posedge clock) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	// Registered read, word appears the cycle after fetch_en
	always_ff @(posedge clock) begin
		if (fetch_en) begin
			insn <= mem[fetch_addr];
		end
	end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
	parameter int                        MEM_WORDS = 1024,
	parameter logic [mips_pkg::XLEN-1:0] START_PC  = 32'h8002_0000
) (
	input  logic                         clock,
	input  logic                         arst_n,
	input  logic                         run,
	output logic                         fetch_en,
	output logic [$clog2(MEM_WORDS)-1:0] fetch_addr,
	output logic                         f_valid,
	output logic [mips_pkg::XLEN-1:0]    f_pc
);

	localparam int AW = $clog2(MEM_WORDS);

	logic [mips_pkg::XLEN-1:0] pc;
	logic [mips_pkg::XLEN-1:0] pc_offset;

	assign fetch_en   = run;
	assign pc_offset  = pc - START_PC;
	assign fetch_addr = pc_offset[AW+1:2];   // Byte offset to word index

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= START_PC;
			f_valid <= 1'b0;
		end else begin
			f_valid <= run;
			if (run) begin
				pc <= pc + 32'd4;
			end
		end
	end

	// Lines up with insn out of the memory
	always_ff @(posedge clock) begin
		f_pc <= pc;
	end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
	input  logic                             clock,
	input  logic                             arst_n,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  rt_addr,
	input  logic                             we,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  waddr,
	input  logic [mips_pkg::XLEN-1:0]        wdata,
	output logic [mips_pkg::XLEN-1:0]        rs_data,
	output logic [mips_pkg::XLEN-1:0]        rt_data
);

	localparam int NREGS = 2 ** mips_pkg::REG_ADDR_W;

	logic [mips_pkg::XLEN-1:0] regs [NREGS];
	logic rs_hit;
	logic rt_hit;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin   // r0 stays zero
			regs[waddr] <= wdata;
		end
	end

	// Write-through on a same-cycle read
	assign rs_hit  = we && (waddr == rs_addr) && (rs_addr != '0);
	assign rt_hit  = we && (waddr == rt_addr) && (rt_addr != '0);
	assign rs_data = rs_hit ? wdata : regs[rs_addr];
	assign rt_data = rt_hit ? wdata : regs[rt_addr];

endmodule

// ==== decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            f_valid,
	input  logic [mips_pkg::XLEN-1:0]       f_pc,
	input  logic [mips_pkg::XLEN-1:0]       insn,
	input  logic [mips_pkg::XLEN-1:0]       rs_data,
	input  logic [mips_pkg::XLEN-1:0]       rt_data,
	output logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
	output logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
	output logic                            d_valid,
	output logic [mips_pkg::XLEN-1:0]       d_pc,
	output mips_pkg::alu_op_e               d_op,
	output logic [mips_pkg::REG_ADDR_W-1:0] d_dest,
	output logic [mips_pkg::XLEN-1:0]       d_a,
	output logic [mips_pkg::XLEN-1:0]       d_b,
	output logic [mips_pkg::SHAMT_W-1:0]    d_shamt
);

	mips_pkg::opcode_e                opcode;
	mips_pkg::funct_e                 funct;
	mips_pkg::alu_op_e                op;
	logic [mips_pkg::REG_ADDR_W-1:0]  rd_field;
	logic [mips_pkg::REG_ADDR_W-1:0]  dest;
	logic [mips_pkg::IMM_W-1:0]       imm;
	logic [mips_pkg::XLEN-1:0]        imm_ext;
	logic supported;
	logic use_imm;
	logic sign_ext;

	assign opcode   = mips_pkg::opcode_e'(insn[mips_pkg::OPCODE_LSB +: mips_pkg::OPCODE_W]);
	assign funct    = mips_pkg::funct_e'(insn[mips_pkg::FUNCT_W-1:0]);
	assign rs_addr  = insn[mips_pkg::RS_LSB +: mips_pkg::REG_ADDR_W];
	assign rt_addr  = insn[mips_pkg::RT_LSB +: mips_pkg::REG_ADDR_W];
	assign rd_field = insn[mips_pkg::RD_LSB +: mips_pkg::REG_ADDR_W];
	assign imm      = insn[mips_pkg::IMM_W-1:0];
	assign imm_ext  = sign_ext ? {{(mips_pkg::XLEN-mips_pkg::IMM_W){imm[mips_pkg::IMM_W-1]}}, imm}
	                           : {{(mips_pkg::XLEN-mips_pkg::IMM_W){1'b0}}, imm};

	always_comb begin
		op        = mips_pkg::ALU_ADD;
		supported = 1'b1;
		use_imm   = 1'b1;
		sign_ext  = 1'b0;
		dest      = rt_addr;   // I-type writes rt
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				use_imm = 1'b0;
				dest    = rd_field;
				case (funct)
					mips_pkg::F_ADD, mips_pkg::F_ADDU: op = mips_pkg::ALU_ADD;   // No overflow trap
					mips_pkg::F_SUB, mips_pkg::F_SUBU: op = mips_pkg::ALU_SUB;
					mips_pkg::F_AND:  op = mips_pkg::ALU_AND;
					mips_pkg::F_OR:   op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR:  op = mips_pkg::ALU_XOR;
					mips_pkg::F_NOR:  op = mips_pkg::ALU_NOR;
					mips_pkg::F_SLT:  op = mips_pkg::ALU_SLT;
					mips_pkg::F_SLTU: op = mips_pkg::ALU_SLTU;
					mips_pkg::F_SLL:  op = mips_pkg::ALU_SLL;
					mips_pkg::F_SRL:  op = mips_pkg::ALU_SRL;
					mips_pkg::F_SRA:  op = mips_pkg::ALU_SRA;
					default: supported = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: sign_ext = 1'b1;
			mips_pkg::OP_SLTI: begin
				op       = mips_pkg::ALU_SLT;
				sign_ext = 1'b1;
			end
			mips_pkg::OP_SLTIU: begin
				op       = mips_pkg::ALU_SLTU;
				sign_ext = 1'b1;   // Sign-extended, then compared unsigned
			end
			mips_pkg::OP_ORI:  op = mips_pkg::ALU_OR;
			mips_pkg::OP_XORI: op = mips_pkg::ALU_XOR;
			mips_pkg::OP_LUI:  op = mips_pkg::ALU_LUI;
			default: supported = 1'b0;   // Loads, stores, branches retire silently
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= f_valid && supported && (dest != '0);
		end
	end

	always_ff @(posedge clock) begin
		d_pc    <= f_pc;
		d_op    <= op;
		d_dest  <= dest;
		d_a     <= rs_data;
		d_b     <= use_imm ? imm_ext : rt_data;
		d_shamt <= insn[mips_pkg::SHAMT_LSB +: mips_pkg::SHAMT_W];
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            d_valid,
	input  logic [mips_pkg::XLEN-1:0]       d_pc,
	input  mips_pkg::alu_op_e               d_op,
	input  logic [mips_pkg::REG_ADDR_W-1:0] d_dest,
	input  logic [mips_pkg::XLEN-1:0]       d_a,
	input  logic [mips_pkg::XLEN-1:0]       d_b,
	input  logic [mips_pkg::SHAMT_W-1:0]    d_shamt,
	output logic                            result_valid,
	output logic [mips_pkg::XLEN-1:0]       result_pc,
	output logic [mips_pkg::REG_ADDR_W-1:0] result_dest,
	output logic [mips_pkg::XLEN-1:0]       result_value
);

	localparam int XLEN  = mips_pkg::XLEN;
	localparam int IMM_W = mips_pkg::IMM_W;

	logic [XLEN-1:0] value;

	always_comb begin
		case (d_op)
			mips_pkg::ALU_ADD:  value = d_a + d_b;
			mips_pkg::ALU_SUB:  value = d_a - d_b;
			mips_pkg::ALU_AND:  value = d_a & d_b;
			mips_pkg::ALU_OR:   value = d_a | d_b;
			mips_pkg::ALU_XOR:  value = d_a ^ d_b;
			mips_pkg::ALU_NOR:  value = ~(d_a | d_b);
			mips_pkg::ALU_SLT:  value = {{(XLEN-1){1'b0}}, $signed(d_a) < $signed(d_b)};
			mips_pkg::ALU_SLTU: value = {{(XLEN-1){1'b0}}, d_a < d_b};
			mips_pkg::ALU_SLL:  value = d_b << d_shamt;
			mips_pkg::ALU_SRL:  value = d_b >> d_shamt;
			mips_pkg::ALU_SRA:  value = $signed(d_b) >>> d_shamt;
			mips_pkg::ALU_LUI:  value = {d_b[XLEN-IMM_W-1:0], {IMM_W{1'b0}}};   // Imm to upper half
			default:            value = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= d_valid;
		end
	end

	always_ff @(posedge clock) begin
		result_pc    <= d_pc;
		result_dest  <= d_dest;
		result_value <= value;
	end

endmodule

// ==== mips_core.sv ====
`timescale 1ns/100ps

module mips_core #(
	parameter int                        MEM_WORDS = 1024,
	parameter logic [mips_pkg::XLEN-1:0] START_PC  = 32'h8002_0000
) (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            load_en,
	input  logic [$clog2(MEM_WORDS)-1:0]    load_addr,
	input  logic [mips_pkg::XLEN-1:0]       load_data,
	input  logic                            run,
	output logic                            result_valid,
	output logic [mips_pkg::XLEN-1:0]       result_pc,
	output logic [mips_pkg::REG_ADDR_W-1:0] result_dest,
	output logic [mips_pkg::XLEN-1:0]       result_value
);

	localparam int AW = $clog2(MEM_WORDS);

	logic                            fetch_en;
	logic [AW-1:0]                   fetch_addr;
	logic [mips_pkg::XLEN-1:0]       insn;
	logic                            f_valid;
	logic [mips_pkg::XLEN-1:0]       f_pc;
	logic [mips_pkg::REG_ADDR_W-1:0] rs_addr, rt_addr;
	logic [mips_pkg::XLEN-1:0]       rs_data, rt_data;
	logic                            d_valid;
	logic [mips_pkg::XLEN-1:0]       d_pc, d_a, d_b;
	mips_pkg::alu_op_e               d_op;
	logic [mips_pkg::REG_ADDR_W-1:0] d_dest;
	logic [mips_pkg::SHAMT_W-1:0]    d_shamt;

	instr_mem #(.MEM_WORDS(MEM_WORDS)) mem0 (.clock, .load_en, .load_addr, .load_data,
		.fetch_en, .fetch_addr, .insn);

	fetch_unit #(.MEM_WORDS(MEM_WORDS), .START_PC(START_PC)) fetch0 (.clock, .arst_n, .run,
		.fetch_en, .fetch_addr, .f_valid, .f_pc);

	decode_unit decode0 (.clock, .arst_n, .f_valid, .f_pc, .insn, .rs_data, .rt_data,
		.rs_addr, .rt_addr, .d_valid, .d_pc, .d_op, .d_dest, .d_a, .d_b, .d_shamt);

	// Writeback straight from the execute result
	reg_file regs0 (.clock, .arst_n, .rs_addr, .rt_addr, .we(result_valid),
		.waddr(result_dest), .wdata(result_value), .rs_data, .rt_data);

	alu alu0 (.clock, .arst_n, .d_valid, .d_pc, .d_op, .d_dest, .d_a, .d_b, .d_shamt,
		.result_valid, .result_pc, .result_dest, .result_value);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 3
) (
	input  logic reset_req,   // Rising edge starts another reset
	output logic clock,
	output logic arst_n
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		arst_n = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge clock);
			@(negedge clock);
			arst_n = 1'b1;
			@(posedge reset_req);
			@(negedge clock);
			arst_n = 1'b0;
		end
	end

endmodule

// ==== mips_asserts.sv ====
`timescale 1ns/100ps

module mips_asserts #(
	parameter int MEM_WORDS = 1024
) (
	input logic                             clock,
	input logic                             arst_n,
	input logic                             result_valid,
	input logic [mips_pkg::REG_ADDR_W-1:0]  result_dest,
	input logic                             fetch_en,
	input logic [$clog2(MEM_WORDS)-1:0]     fetch_addr
);

	localparam int AW = $clog2(MEM_WORDS);

	// No retirement during reset or before the pipeline can refill
	reset_quiet: assert property (@(posedge clock)
		(!arst_n || !$past(arst_n) || !$past(arst_n, 2) || !$past(arst_n, 3))
		|-> !result_valid)
		else $error("result_valid high during or right after reset");

	dest_nonzero: assert property (@(posedge clock) disable iff (!arst_n)
		result_valid |-> result_dest != '0)
		else $error("result reported for register 0");

	// Sequential fetch, one word per enabled cycle
	fetch_step: assert property (@(posedge clock) disable iff (!arst_n)
		fetch_en && $past(fetch_en) |-> fetch_addr == AW'($past(fetch_addr) + 1'b1))
		else $error("fetch_addr did not advance by one word");

endmodule

bind mips_core mips_asserts #(.MEM_WORDS(MEM_WORDS)) asserts0 (
	.clock, .arst_n, .result_valid, .result_dest, .fetch_en, .fetch_addr
);

// ==== mips_tb.sv ====
`timescale 1ns/100ps

module mips_tb;

	localparam logic [31:0] START_PC = 32'h8002_0000;
	localparam int TIMEOUT = 200;   // Cycles allowed per wait

	logic        clock;
	logic        arst_n;
	logic        reset_req;
	logic        load_en;
	logic [9:0]  load_addr;
	logic [31:0] load_data;
	logic        run;
	logic        result_valid;
	logic [31:0] result_pc;
	logic [4:0]  result_dest;
	logic [31:0] result_value;

	integer      seed;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_errs_start;
	logic [31:0] prog [$];
	logic [31:0] exp_pc [$];
	logic [4:0]  exp_dest [$];
	logic [31:0] exp_val [$];
	logic [31:0] got_val [$];

	tb_clock_gen clk_gen0 (.reset_req, .clock, .arst_n);

	mips_core dut0 (.clock, .arst_n, .load_en, .load_addr, .load_data, .run,
		.result_valid, .result_pc, .result_dest, .result_value);

	function automatic logic [31:0] random_word();
		return $random(seed);
	endfunction

	function automatic logic [31:0] rtype_word(input int funct, input int rd, input int rs,
		input int rt, input logic [31:0] shamt);
		return {6'd0, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
	endfunction

	function automatic logic [31:0] itype_word(input int opcode, input int rt, input int rs,
		input logic [31:0] imm);
		return {opcode[5:0], rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// LUI all, then ORI all, so no ORI follows its own LUI directly
	task automatic build_constants(input int first, input int count, input bit alt_sign);
		logic [31:0] vals [$];
		logic [31:0] w;
		for (int k = 0; k < count; k++) begin
			w = random_word();
			if (alt_sign)
				w[31] = (k % 2 == 0);   // Even ones negative
			vals.push_back(w);
			prog.push_back(itype_word(6'h0f, first + k, 0, w[31:16]));
		end
		for (int k = 0; k < count; k++)
			prog.push_back(itype_word(6'h0d, first + k, first + k, vals[k][15:0]));
		prog.push_back(32'h0);
	endtask

	// In-order reference, r0 stays zero
	task automatic model_run();
		logic [31:0] regs [32];
		logic [31:0] w, a, b, se, ze, v;
		logic [4:0]  dest;
		bit          ok;
		foreach (regs[i])
			regs[i] = '0;
		exp_pc.delete();
		exp_dest.delete();
		exp_val.delete();
		for (int i = 0; i < prog.size(); i++) begin
			w    = prog[i];
			a    = regs[w[25:21]];
			b    = regs[w[20:16]];
			se   = {{16{w[15]}}, w[15:0]};
			ze   = {16'h0, w[15:0]};
			dest = w[20:16];
			ok   = 1'b1;
			v    = '0;
			case (w[31:26])
				6'h00: begin
					dest = w[15:11];
					case (w[5:0])
						6'h20, 6'h21: v = a + b;
						6'h22, 6'h23: v = a - b;
						6'h24: v = a & b;
						6'h25: v = a | b;
						6'h26: v = a ^ b;
						6'h27: v = ~(a | b);
						6'h2a: v = {31'd0, $signed(a) < $signed(b)};
						6'h2b: v = {31'd0, a < b};
						6'h00: v = b << w[10:6];
						6'h02: v = b >> w[10:6];
						6'h03: v = $signed(b) >>> w[10:6];
						default: ok = 1'b0;
					endcase
				end
				6'h08, 6'h09: v = a + se;
				6'h0a: v = {31'd0, $signed(a) < $signed(se)};
				6'h0b: v = {31'd0, a < se};
				6'h0d: v = a | ze;
				6'h0e: v = a ^ ze;
				6'h0f: v = {w[15:0], 16'h0};
				default: ok = 1'b0;
			endcase
			if (ok && dest != 5'd0) begin
				regs[dest] = v;
				exp_pc.push_back(START_PC + 32'(4 * i));
				exp_dest.push_back(dest);
				exp_val.push_back(v);
			end
		end
	endtask

	task automatic reset_dut();
		int t;
		t = 0;
		@(negedge clock);
		run       = 1'b0;
		load_en   = 1'b0;
		reset_req = 1'b1;
		while (arst_n && t < TIMEOUT) begin
			@(negedge clock);
			t++;
		end
		reset_req = 1'b0;
		while (!arst_n && t < TIMEOUT) begin
			@(negedge clock);
			t++;
		end
		if (t >= TIMEOUT) begin
			$display("Reset did not complete within %0d cycles", TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_result(input int k);
		got_val.push_back(result_value);
		if (result_pc !== exp_pc[k] || result_dest !== exp_dest[k]
			|| result_value !== exp_val[k]) begin
			$display("Fail at %0t: result %0d pc %h r%0d = %h, expected pc %h r%0d = %h",
				$time, k, result_pc, result_dest, result_value, exp_pc[k], exp_dest[k],
				exp_val[k]);
			errors++;
		end
	endtask

	// Load, run, collect; run may drop at pause_at issued words
	task automatic run_program(input string name, input int pause_at, input int pause_len);
		int issued;
		int hold;
		int cycles;
		int got;
		test_errs_start = errors;
		issued = 0;
		hold   = 0;
		cycles = 0;
		got    = 0;
		reset_dut();
		foreach (prog[i]) begin
			load_en   = 1'b1;
			load_addr = 10'(i);
			load_data = prog[i];
			@(negedge clock);
		end
		load_en = 1'b0;
		model_run();
		got_val.delete();
		run = 1'b1;
		while (got < exp_val.size() && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
			if (run)
				issued++;   // Fetched at the last rising edge
			if (result_valid) begin
				check_result(got);
				got++;
			end
			if (issued == pause_at && hold < pause_len) begin
				run = 1'b0;
				hold++;
			end else begin
				run = (issued < prog.size());
			end
		end
		run = 1'b0;
		if (got < exp_val.size()) begin
			$display("Timeout in %s: only %0d of %0d results arrived", name, got,
				exp_val.size());
			errors++;
		end
		// In-flight words left must retire silently
		repeat (4) begin
			@(negedge clock);
			if (result_valid) begin
				$display("Unexpected extra result in %s for pc %h", name, result_pc);
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors != test_errs_start)
			tests_failed++;
		$display("Test %s finished with %0d errors", name, errors - test_errs_start);
	endtask

	task automatic alu_logic_ops();
		prog.delete();
		build_constants(1, 4, 1'b0);
		prog.push_back(rtype_word(6'h21, 5, 1, 2, 0));    // ADDU
		prog.push_back(rtype_word(6'h23, 6, 3, 4, 0));    // SUBU
		prog.push_back(rtype_word(6'h24, 7, 1, 3, 0));
		prog.push_back(rtype_word(6'h25, 8, 2, 4, 0));
		prog.push_back(rtype_word(6'h26, 9, 5, 1, 0));
		prog.push_back(rtype_word(6'h27, 10, 6, 2, 0));   // NOR
		prog.push_back(rtype_word(6'h20, 11, 7, 8, 0));
		prog.push_back(rtype_word(6'h22, 12, 9, 10, 0));
		run_program("alu_logic", -1, 0);
		report_test("alu_logic");
	endtask

	task automatic shift_ops();
		prog.delete();
		build_constants(1, 3, 1'b1);
		prog.push_back(rtype_word(6'h00, 4, 0, 1, random_word()));   // SLL
		prog.push_back(rtype_word(6'h02, 5, 0, 1, random_word()));
		prog.push_back(rtype_word(6'h03, 6, 0, 1, random_word()));   // SRA of a negative
		prog.push_back(rtype_word(6'h03, 7, 0, 2, random_word()));
		prog.push_back(rtype_word(6'h03, 8, 0, 3, 31));
		prog.push_back(rtype_word(6'h02, 9, 0, 3, 0));
		run_program("shifts", -1, 0);
		report_test("shifts");
	endtask

	task automatic immediate_ops();
		prog.delete();
		build_constants(1, 2, 1'b1);
		prog.push_back(itype_word(6'h09, 3, 1, random_word() | 32'h8000));   // ADDIU
		prog.push_back(itype_word(6'h08, 4, 2, random_word() | 32'h8000));
		prog.push_back(itype_word(6'h0a, 5, 2, random_word() | 32'h8000));   // SLTI
		prog.push_back(itype_word(6'h0a, 6, 1, 32'hffff));
		prog.push_back(itype_word(6'h0b, 7, 2, random_word() | 32'h8000));
		prog.push_back(itype_word(6'h0d, 8, 1, random_word() | 32'h8000));   // ORI
		prog.push_back(itype_word(6'h0e, 9, 2, random_word() | 32'h8000));
		prog.push_back(itype_word(6'h0f, 10, 0, random_word()));
		run_program("immediates", -1, 0);
		report_test("immediates");
	endtask

	task automatic signed_compare();
		prog.delete();
		build_constants(1, 2, 1'b1);   // r1 negative, r2 positive
		prog.push_back(rtype_word(6'h2a, 3, 1, 2, 0));
		prog.push_back(rtype_word(6'h2b, 4, 1, 2, 0));
		prog.push_back(rtype_word(6'h2a, 5, 2, 1, 0));
		prog.push_back(rtype_word(6'h2b, 6, 2, 1, 0));
		run_program("signed_compare", -1, 0);
		if (got_val.size() < 8 || got_val[4] == got_val[5] || got_val[6] == got_val[7]) begin
			$display("Fail at %0t: SLT and SLTU gave the same answer on opposite signs",
				$time);
			errors++;
		end
		report_test("signed_compare");
	endtask

	task automatic silent_retire();
		prog.delete();
		build_constants(1, 2, 1'b0);
		prog.push_back(rtype_word(6'h21, 0, 1, 2, 0));   // Write to r0
		prog.push_back(itype_word(6'h23, 3, 1, 0));      // LW
		prog.push_back(rtype_word(6'h21, 4, 1, 2, 0));
		prog.push_back(32'h0);
		prog.push_back(itype_word(6'h0d, 0, 1, random_word()));
		prog.push_back(rtype_word(6'h25, 5, 3, 1, 0));   // r3 never written
		prog.push_back(rtype_word(6'h0d, 6, 1, 2, 0));
		prog.push_back(rtype_word(6'h26, 7, 4, 0, 0));
		run_program("silent_retire", -1, 0);
		report_test("silent_retire");
	endtask

	task automatic pause_resume();
		prog.delete();
		build_constants(1, 3, 1'b0);
		prog.push_back(rtype_word(6'h21, 4, 1, 2, 0));
		prog.push_back(rtype_word(6'h23, 5, 2, 3, 0));
		prog.push_back(rtype_word(6'h26, 6, 1, 3, 0));
		prog.push_back(rtype_word(6'h25, 7, 4, 5, 0));
		prog.push_back(itype_word(6'h09, 8, 6, random_word()));
		prog.push_back(rtype_word(6'h27, 9, 7, 1, 0));
		run_program("pause_resume", 9, 5);
		report_test("pause_resume");
	endtask

	initial begin
		seed         = 32'h499122ab;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset_req    = 1'b0;
		load_en      = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		run          = 1'b0;
		alu_logic_ops();
		shift_ops();
		immediate_ops();
		signed_compare();
		silent_retire();
		pause_resume();
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
mips_pkg.sv
instr_mem.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
alu.sv
mips_core.sv
tb_clock_gen.sv
mips_asserts.sv
mips_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the simulation with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module mips_tb -f all.f \
	-o mips_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mips_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: PASSED" sim.log; then
	exit 0
fi
exit 1
